//--- rv_decode_pkg.sv
// widths are fixed by RV32I; alu op bit positions must match the execute stage's decoding
`default_nettype none

package rv_decode_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [11:0] csr_addr_t;
	typedef logic [6:0] opcode_t;
	typedef logic [17:0] alu_op_t;

	localparam int NUM_REGS = 32;

	// bit positions inside the one-hot alu op word
	localparam int OP_ADD = 0;
	localparam int OP_SUB = 1;
	localparam int OP_SLT = 2;
	localparam int OP_SLTU = 3;
	localparam int OP_AND = 4;
	// reserved, never set by decode
	localparam int OP_NOR = 5;
	localparam int OP_OR = 6;
	localparam int OP_XOR = 7;
	localparam int OP_SLL = 8;
	localparam int OP_SRL = 9;
	localparam int OP_SRA = 10;
	localparam int OP_LUI = 11;
	localparam int OP_BEQ = 12;
	localparam int OP_BNE = 13;
	localparam int OP_BLT = 14;
	localparam int OP_BLTU = 15;
	localparam int OP_BGE = 16;
	localparam int OP_BGEU = 17;

	// major opcodes
	localparam opcode_t OPC_OP_IMM = 7'b001_0011;
	localparam opcode_t OPC_OP = 7'b011_0011;
	localparam opcode_t OPC_LUI = 7'b011_0111;
	localparam opcode_t OPC_AUIPC = 7'b001_0111;
	localparam opcode_t OPC_JAL = 7'b110_1111;
	localparam opcode_t OPC_JALR = 7'b110_0111;
	localparam opcode_t OPC_BRANCH = 7'b110_0011;
	localparam opcode_t OPC_LOAD = 7'b000_0011;
	localparam opcode_t OPC_STORE = 7'b010_0011;
	localparam opcode_t OPC_SYSTEM = 7'b111_0011;

	// full encodings of the operand-less system instructions
	localparam word_t INST_ECALL = 32'h0000_0073;
	localparam word_t INST_EBREAK = 32'h0010_0073;
	localparam word_t INST_MRET = 32'h3020_0073;

	localparam csr_addr_t CSR_MSTATUS = 12'h300;
	localparam csr_addr_t CSR_MTVEC = 12'h305;
	localparam csr_addr_t CSR_MEPC = 12'h341;
	localparam csr_addr_t CSR_MCAUSE = 12'h342;

	typedef struct packed {
		word_t pc;
		word_t inst;
	} fetch_bus_t;

	typedef struct packed {
		word_t src1;
		word_t src2;
		reg_addr_t rd;
		alu_op_t op;
	} alu_bus_t;

	typedef struct packed {
		logic [1:0] wb_sel;
		logic [2:0] store_kind;
		logic [4:0] load_kind;
		word_t store_data;
		logic [1:0] jump_kind;
		word_t branch_target;
		logic is_branch;
		word_t pc;
		word_t inst;
	} exu_bus_t;

	typedef struct packed {
		csr_addr_t csr_idx;
		logic [2:0] csr_kind;
		word_t next_pc;
		logic next_pc_taken;
	} csr_bus_t;

endpackage

`default_nettype wire

//--- reg_file.sv
// x0 always reads zero and drops writes; reads see a write only after its edge, no bypass
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_decode_pkg::*; (
	input wire clock,
	input wire reset,
	input wire reg_addr_t raddr1,
	input wire reg_addr_t raddr2,
	output word_t rdata1,
	output word_t rdata2,
	input wire wen,
	input wire reg_addr_t waddr,
	input wire word_t wdata
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// index 0 is hardwired, whatever the array holds
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	// write-back from execute must never carry an unresolved index
	a_waddr_known: assert property (
		@(posedge clock) disable iff (reset) wen |-> !$isunknown(waddr)
	);

endmodule

`default_nettype wire

//--- csr_file.sv
// only mstatus, mtvec, mepc, mcause exist; other addresses read zero and drop writes
`timescale 1ns/1ps
`default_nettype none

module csr_file import rv_decode_pkg::*; (
	input wire clock,
	input wire reset,
	input wire csr_addr_t raddr,
	output word_t rdata,
	input wire wen,
	input wire csr_addr_t waddr,
	input wire word_t wdata
);

	word_t mstatus;
	word_t mtvec;
	word_t mepc;
	word_t mcause;

	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus <= '0;
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
		end else if (wen) begin
			case (waddr)
				CSR_MSTATUS: mstatus <= wdata;
				CSR_MTVEC: mtvec <= wdata;
				CSR_MEPC: mepc <= wdata;
				CSR_MCAUSE: mcause <= wdata;
				default: ;
			endcase
		end
	end

	// combinational read, used by decode in the same cycle
	always_comb begin
		case (raddr)
			CSR_MSTATUS: rdata = mstatus;
			CSR_MTVEC: rdata = mtvec;
			CSR_MEPC: rdata = mepc;
			CSR_MCAUSE: rdata = mcause;
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- decode_stage.sv
// one-entry stage; legal RV32I plus csrrw/csrrs/ecall/ebreak/mret only, no hazard checks
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_decode_pkg::*; (
	input wire clock,
	input wire reset,
	input wire fetch_bus_t fetch_bus,
	input wire fetch_valid,
	output logic decode_allowin,
	input wire exu_allowin,
	output logic decode_valid,
	output alu_bus_t alu_bus,
	output exu_bus_t exu_bus,
	output csr_bus_t csr_bus,
	output csr_addr_t csr_raddr,
	input wire word_t csr_rdata,
	input wire rf_wen,
	input wire reg_addr_t rf_waddr,
	input wire word_t rf_wdata
);

	fetch_bus_t held;
	word_t pc;
	word_t inst;
	opcode_t opcode;
	logic [2:0] funct3;
	logic f7_zero;
	logic f7_alt;
	word_t rs1_data;
	word_t rs2_data;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j, imm;
	logic inst_addi, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori;
	logic inst_slli, inst_srli, inst_srai, inst_lui, inst_auipc;
	logic inst_add, inst_sub, inst_slt, inst_sltu, inst_and, inst_or;
	logic inst_xor, inst_sll, inst_srl, inst_sra;
	logic inst_jal, inst_jalr, inst_beq, inst_bne, inst_blt, inst_bltu, inst_bge, inst_bgeu;
	logic inst_lw, inst_lh, inst_lhu, inst_lb, inst_lbu, inst_sw, inst_sh, inst_sb;
	logic inst_ecall, inst_ebreak, inst_mret, inst_csrrw, inst_csrrs;
	logic is_load, is_store, is_branch, is_csr_rw, inst_legal;
	logic imm_is_i, imm_is_u, imm_is_s;
	alu_op_t op;

	// execute takes one item per cycle, so the slot frees whenever execute accepts
	assign decode_allowin = !decode_valid || exu_allowin;

	always_ff @(posedge clock) begin
		if (reset) begin
			decode_valid <= 1'b0;
		end else if (decode_allowin) begin
			decode_valid <= fetch_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (decode_allowin) begin
			held <= fetch_bus;
		end
	end

	assign pc = held.pc;
	assign inst = held.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign f7_zero = inst[31:25] == 7'b000_0000;
	assign f7_alt = inst[31:25] == 7'b010_0000;

	// register-immediate
	assign inst_addi = opcode == OPC_OP_IMM && funct3 == 3'b000;
	assign inst_slti = opcode == OPC_OP_IMM && funct3 == 3'b010;
	assign inst_sltiu = opcode == OPC_OP_IMM && funct3 == 3'b011;
	assign inst_xori = opcode == OPC_OP_IMM && funct3 == 3'b100;
	assign inst_ori = opcode == OPC_OP_IMM && funct3 == 3'b110;
	assign inst_andi = opcode == OPC_OP_IMM && funct3 == 3'b111;
	assign inst_slli = opcode == OPC_OP_IMM && funct3 == 3'b001;
	// shift kind picked by bit 30 alone
	assign inst_srli = opcode == OPC_OP_IMM && funct3 == 3'b101 && !inst[30];
	assign inst_srai = opcode == OPC_OP_IMM && funct3 == 3'b101 && inst[30];
	assign inst_lui = opcode == OPC_LUI;
	assign inst_auipc = opcode == OPC_AUIPC;

	// register-register
	assign inst_add = opcode == OPC_OP && funct3 == 3'b000 && f7_zero;
	assign inst_sub = opcode == OPC_OP && funct3 == 3'b000 && f7_alt;
	assign inst_sll = opcode == OPC_OP && funct3 == 3'b001 && f7_zero;
	assign inst_slt = opcode == OPC_OP && funct3 == 3'b010 && f7_zero;
	assign inst_sltu = opcode == OPC_OP && funct3 == 3'b011 && f7_zero;
	assign inst_xor = opcode == OPC_OP && funct3 == 3'b100 && f7_zero;
	assign inst_srl = opcode == OPC_OP && funct3 == 3'b101 && f7_zero;
	assign inst_sra = opcode == OPC_OP && funct3 == 3'b101 && f7_alt;
	assign inst_or = opcode == OPC_OP && funct3 == 3'b110 && f7_zero;
	assign inst_and = opcode == OPC_OP && funct3 == 3'b111 && f7_zero;

	// jumps and branches
	assign inst_jal = opcode == OPC_JAL;
	assign inst_jalr = opcode == OPC_JALR && funct3 == 3'b000;
	assign inst_beq = opcode == OPC_BRANCH && funct3 == 3'b000;
	assign inst_bne = opcode == OPC_BRANCH && funct3 == 3'b001;
	assign inst_blt = opcode == OPC_BRANCH && funct3 == 3'b100;
	assign inst_bge = opcode == OPC_BRANCH && funct3 == 3'b101;
	assign inst_bltu = opcode == OPC_BRANCH && funct3 == 3'b110;
	assign inst_bgeu = opcode == OPC_BRANCH && funct3 == 3'b111;

	// loads and stores
	assign inst_lb = opcode == OPC_LOAD && funct3 == 3'b000;
	assign inst_lh = opcode == OPC_LOAD && funct3 == 3'b001;
	assign inst_lw = opcode == OPC_LOAD && funct3 == 3'b010;
	assign inst_lbu = opcode == OPC_LOAD && funct3 == 3'b100;
	assign inst_lhu = opcode == OPC_LOAD && funct3 == 3'b101;
	assign inst_sb = opcode == OPC_STORE && funct3 == 3'b000;
	assign inst_sh = opcode == OPC_STORE && funct3 == 3'b001;
	assign inst_sw = opcode == OPC_STORE && funct3 == 3'b010;

	// system
	assign inst_ecall = inst == INST_ECALL;
	assign inst_ebreak = inst == INST_EBREAK;
	assign inst_mret = inst == INST_MRET;
	assign inst_csrrw = opcode == OPC_SYSTEM && funct3 == 3'b001;
	assign inst_csrrs = opcode == OPC_SYSTEM && funct3 == 3'b010;

	assign is_load = inst_lw | inst_lh | inst_lhu | inst_lb | inst_lbu;
	assign is_store = inst_sw | inst_sh | inst_sb;
	assign is_branch = inst_beq | inst_bne | inst_blt | inst_bltu | inst_bge | inst_bgeu;
	assign is_csr_rw = inst_csrrw | inst_csrrs;

	assign inst_legal = inst_addi | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori
		| inst_slli | inst_srli | inst_srai | inst_lui | inst_auipc
		| inst_add | inst_sub | inst_slt | inst_sltu | inst_and | inst_or
		| inst_xor | inst_sll | inst_srl | inst_sra
		| inst_jal | inst_jalr | is_branch | is_load | is_store
		| inst_ecall | inst_ebreak | inst_mret | is_csr_rw;

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	assign imm_is_i = inst_addi | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori
		| inst_slli | inst_srli | inst_srai | inst_jalr | is_load;
	assign imm_is_u = inst_lui | inst_auipc;
	assign imm_is_s = is_store;
	assign imm = ({32{imm_is_i}} & imm_i) | ({32{imm_is_u}} & imm_u)
		| ({32{inst_jal}} & imm_j) | ({32{imm_is_s}} & imm_s);

	reg_file u_reg_file (
		.clock(clock),
		.reset(reset),
		.raddr1(inst[19:15]),
		.raddr2(inst[24:20]),
		.rdata1(rs1_data),
		.rdata2(rs2_data),
		.wen(rf_wen),
		.waddr(rf_waddr),
		.wdata(rf_wdata)
	);

	always_comb begin
		op = '0;
		op[OP_ADD] = inst_addi | inst_add | inst_auipc | inst_jal | inst_jalr | is_load | is_store;
		op[OP_SUB] = inst_sub;
		op[OP_SLT] = inst_slti | inst_slt;
		op[OP_SLTU] = inst_sltiu | inst_sltu;
		op[OP_AND] = inst_andi | inst_and;
		op[OP_NOR] = 1'b0;
		// csrrs computes csr | rs1 in the alu
		op[OP_OR] = inst_ori | inst_or | inst_csrrs;
		op[OP_XOR] = inst_xori | inst_xor;
		op[OP_SLL] = inst_slli | inst_sll;
		op[OP_SRL] = inst_srli | inst_srl;
		op[OP_SRA] = inst_srai | inst_sra;
		op[OP_LUI] = inst_lui;
		op[OP_BEQ] = inst_beq;
		op[OP_BNE] = inst_bne;
		op[OP_BLT] = inst_blt;
		op[OP_BLTU] = inst_bltu;
		op[OP_BGE] = inst_bge;
		op[OP_BGEU] = inst_bgeu;
	end

	assign csr_raddr = inst_ecall ? CSR_MTVEC
		: inst_mret ? CSR_MEPC
		: is_csr_rw ? inst[31:20]
		: '0;

	always_comb begin
		alu_bus.src1 = (inst_jal | inst_auipc) ? pc : inst_lui ? '0 : rs1_data;
		alu_bus.src2 = (imm_is_i | imm_is_u | inst_jal | imm_is_s) ? imm
			: is_csr_rw ? csr_rdata : rs2_data;
		alu_bus.rd = inst[11:7];
		alu_bus.op = op;

		// bit 1 stores to memory, bit 0 writes a register
		exu_bus.wb_sel = {is_store, ~(is_store | is_branch)};
		exu_bus.store_kind = {inst_sb, inst_sh, inst_sw};
		exu_bus.load_kind = {inst_lbu, inst_lb, inst_lhu, inst_lh, inst_lw};
		exu_bus.store_data = rs2_data;
		exu_bus.jump_kind = {inst_jalr, inst_jal};
		exu_bus.branch_target = pc + imm_b;
		exu_bus.is_branch = is_branch;
		exu_bus.pc = pc;
		exu_bus.inst = inst;

		csr_bus.csr_idx = inst[31:20];
		csr_bus.csr_kind = {inst_ecall, inst_csrrs, inst_csrrw};
		csr_bus.next_pc = {32{inst_ecall | inst_mret}} & csr_rdata;
		csr_bus.next_pc_taken = inst_ecall | inst_mret;
	end

	a_legal_inst: assert property (
		@(posedge clock) disable iff (reset) decode_valid |-> inst_legal
	);

	// a stalled item must not change or vanish before execute takes it
	a_hold_stalled: assert property (
		@(posedge clock) disable iff (reset)
		(decode_valid && !exu_allowin) |=> (decode_valid && $stable(held))
	);

endmodule

`default_nettype wire

//--- decode_top.sv
// write-back and CSR writes come from outside; no exception entry updates mepc or mcause
`timescale 1ns/1ps
`default_nettype none

module decode_top import rv_decode_pkg::*; (
	input wire clock,
	input wire reset,
	input wire fetch_bus_t fetch_bus,
	input wire fetch_valid,
	output logic decode_allowin,
	input wire exu_allowin,
	output logic decode_valid,
	output alu_bus_t alu_bus,
	output exu_bus_t exu_bus,
	output csr_bus_t csr_bus,
	input wire rf_wen,
	input wire reg_addr_t rf_waddr,
	input wire word_t rf_wdata,
	input wire csr_wen,
	input wire csr_addr_t csr_waddr,
	input wire word_t csr_wdata
);

	csr_addr_t csr_raddr;
	word_t csr_rdata;

	decode_stage u_decode_stage (
		.clock(clock),
		.reset(reset),
		.fetch_bus(fetch_bus),
		.fetch_valid(fetch_valid),
		.decode_allowin(decode_allowin),
		.exu_allowin(exu_allowin),
		.decode_valid(decode_valid),
		.alu_bus(alu_bus),
		.exu_bus(exu_bus),
		.csr_bus(csr_bus),
		.csr_raddr(csr_raddr),
		.csr_rdata(csr_rdata),
		.rf_wen(rf_wen),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata)
	);

	// read port serves decode, write port is driven from outside
	csr_file u_csr_file (
		.clock(clock),
		.reset(reset),
		.raddr(csr_raddr),
		.rdata(csr_rdata),
		.wen(csr_wen),
		.waddr(csr_waddr),
		.wdata(csr_wdata)
	);

endmodule

`default_nettype wire

//--- tb_decode_top.sv
// drives legal instructions only; register and CSR writes happen only while exu_allowin is high
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top import rv_decode_pkg::*; ();

	logic clock;
	logic reset;
	fetch_bus_t fetch_bus;
	logic fetch_valid;
	logic decode_allowin;
	logic exu_allowin;
	logic decode_valid;
	alu_bus_t alu_bus;
	exu_bus_t exu_bus;
	csr_bus_t csr_bus;
	logic rf_wen;
	reg_addr_t rf_waddr;
	word_t rf_wdata;
	logic csr_wen;
	csr_addr_t csr_waddr;
	word_t csr_wdata;

	integer seed = 32'hd251;
	word_t shadow_regs [32];
	// mstatus, mtvec, mepc, mcause
	word_t shadow_csrs [4];
	fetch_bus_t pending [$];
	logic stalled = 1'b0;
	alu_bus_t saved_alu;
	exu_bus_t saved_exu;
	csr_bus_t saved_csr;
	alu_bus_t exp_alu;
	exu_bus_t exp_exu;
	csr_bus_t exp_csr;
	fetch_bus_t item;
	word_t stim [300];
	int idx;
	int waited;
	logic took;

	decode_top dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic report_mismatch(string name, logic [159:0] expected, logic [159:0] actual);
		$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		$display("Simulation failed");
		$fatal(1, "mismatch");
	endtask

	task automatic report_error(string what);
		$display("error: %s", what);
		$display("Simulation failed");
		$fatal(1, "error");
	endtask

	function automatic void decode_ref(input word_t pc, input word_t inst,
		input word_t regs [32], input word_t csrs [4],
		output alu_bus_t a, output exu_bus_t e, output csr_bus_t c);
		logic [2:0] f3;
		word_t rs1, rs2, csr_val;
		word_t imm_i, imm_s, imm_b, imm_u, imm_j;
		f3 = inst[14:12];
		rs1 = regs[inst[19:15]];
		rs2 = regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_u = {inst[31:12], 12'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		case (inst[31:20])
			CSR_MSTATUS: csr_val = csrs[0];
			CSR_MTVEC: csr_val = csrs[1];
			CSR_MEPC: csr_val = csrs[2];
			CSR_MCAUSE: csr_val = csrs[3];
			default: csr_val = '0;
		endcase
		a = '0;
		e = '0;
		c = '0;
		a.src1 = rs1;
		a.src2 = rs2;
		a.rd = inst[11:7];
		e.wb_sel = 2'b01;
		e.store_data = rs2;
		e.branch_target = pc + imm_b;
		e.pc = pc;
		e.inst = inst;
		c.csr_idx = inst[31:20];
		case (inst[6:0])
			OPC_OP_IMM, OPC_OP: begin
				if (inst[6:0] == OPC_OP_IMM)
					a.src2 = imm_i;
				case (f3)
					3'b000: a.op[(inst[5] && inst[30]) ? OP_SUB : OP_ADD] = 1'b1;
					3'b001: a.op[OP_SLL] = 1'b1;
					3'b010: a.op[OP_SLT] = 1'b1;
					3'b011: a.op[OP_SLTU] = 1'b1;
					3'b100: a.op[OP_XOR] = 1'b1;
					3'b101: a.op[inst[30] ? OP_SRA : OP_SRL] = 1'b1;
					3'b110: a.op[OP_OR] = 1'b1;
					default: a.op[OP_AND] = 1'b1;
				endcase
			end
			OPC_LUI: begin
				a.src1 = '0;
				a.src2 = imm_u;
				a.op[OP_LUI] = 1'b1;
			end
			OPC_AUIPC, OPC_JAL: begin
				a.src1 = pc;
				a.src2 = (inst[6:0] == OPC_JAL) ? imm_j : imm_u;
				a.op[OP_ADD] = 1'b1;
				e.jump_kind = (inst[6:0] == OPC_JAL) ? 2'b01 : 2'b00;
			end
			OPC_JALR, OPC_LOAD: begin
				a.src2 = imm_i;
				a.op[OP_ADD] = 1'b1;
				if (inst[6:0] == OPC_JALR)
					e.jump_kind = 2'b10;
				else
					e.load_kind = (f3 == 3'b010) ? 5'b00001 : (f3 == 3'b001) ? 5'b00010
						: (f3 == 3'b101) ? 5'b00100 : (f3 == 3'b000) ? 5'b01000 : 5'b10000;
			end
			OPC_STORE: begin
				a.src2 = imm_s;
				a.op[OP_ADD] = 1'b1;
				e.wb_sel = 2'b10;
				e.store_kind = (f3 == 3'b010) ? 3'b001 : (f3 == 3'b001) ? 3'b010 : 3'b100;
			end
			OPC_BRANCH: begin
				e.wb_sel = 2'b00;
				e.is_branch = 1'b1;
				a.op[(f3 == 3'b000) ? OP_BEQ : (f3 == 3'b001) ? OP_BNE : (f3 == 3'b100) ? OP_BLT
					: (f3 == 3'b101) ? OP_BGE : (f3 == 3'b110) ? OP_BLTU : OP_BGEU] = 1'b1;
			end
			default: begin
				if (f3 == 3'b001 || f3 == 3'b010) begin
					a.src2 = csr_val;
					a.op[OP_OR] = (f3 == 3'b010);
					c.csr_kind = (f3 == 3'b010) ? 3'b010 : 3'b001;
				end else if (inst == INST_ECALL) begin
					c.csr_kind = 3'b100;
					c.next_pc = csrs[1];
					c.next_pc_taken = 1'b1;
				end else if (inst == INST_MRET) begin
					c.next_pc = csrs[2];
					c.next_pc_taken = 1'b1;
				end
			end
		endcase
	endfunction

	function automatic word_t rand_inst();
		word_t r;
		logic [2:0] f3;
		int unsigned k;
		csr_addr_t addrs [5] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, 12'h7c0};
		r = $random(seed);
		f3 = r[14:12];
		k = {$random(seed)} % 9;
		case (k)
			0: begin
				if (f3 == 3'b001 || f3 == 3'b101)
					r[31:25] = {1'b0, r[30] & f3[2], 5'b0};
				r[6:0] = OPC_OP_IMM;
			end
			1: begin
				r[31:25] = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, r[30], 5'b0} : 7'h00;
				r[6:0] = OPC_OP;
			end
			2: r[6:0] = r[31] ? OPC_LUI : OPC_AUIPC;
			3: r[6:0] = OPC_JAL;
			4: r = {r[31:15], 3'b000, r[11:7], OPC_JALR};
			5: r = {r[31:15], (f3 == 3'd2 || f3 == 3'd3) ? (f3 | 3'd4) : f3, r[11:7], OPC_BRANCH};
			6: r = {r[31:15], (f3 == 3'd3) ? 3'd2 : (f3 > 3'd5) ? f3 - 3'd2 : f3, r[11:7], OPC_LOAD};
			7: r = {r[31:15], f3 % 3'd3, r[11:7], OPC_STORE};
			default: begin
				case (r[1:0])
					2'd0: r = INST_ECALL;
					2'd1: r = INST_MRET;
					2'd2: r = INST_EBREAK;
					// funct3 is 001 for csrrw or 010 for csrrs
					default: r = {addrs[{$random(seed)} % 5], r[19:15],
						1'b0, f3[0], ~f3[0], r[11:7], OPC_SYSTEM};
				endcase
			end
		endcase
		return r;
	endfunction

	// compare leaving items first, then record the item accepted at the coming edge
	always @(negedge clock) begin
		if (!reset) begin
			// the stage is occupied exactly while an accepted item has not left
			assert (decode_valid === (pending.size() != 0))
			else report_mismatch("decode_valid", pending.size() != 0, decode_valid);
			assert (decode_allowin === (pending.size() == 0 || exu_allowin))
			else report_mismatch("decode_allowin", pending.size() == 0 || exu_allowin,
				decode_allowin);
			if (stalled && decode_valid) begin
				assert (alu_bus === saved_alu && exu_bus === saved_exu && csr_bus === saved_csr)
				else report_error("outputs changed while execute was stalled");
			end
			stalled = decode_valid && !exu_allowin;
			saved_alu = alu_bus;
			saved_exu = exu_bus;
			saved_csr = csr_bus;
			if (decode_valid && exu_allowin) begin
				item = pending.pop_front();
				decode_ref(item.pc, item.inst, shadow_regs, shadow_csrs, exp_alu, exp_exu, exp_csr);
				assert (alu_bus === exp_alu) else report_mismatch("alu_bus", exp_alu, alu_bus);
				assert (exu_bus === exp_exu) else report_mismatch("exu_bus", exp_exu, exu_bus);
				assert (csr_bus === exp_csr) else report_mismatch("csr_bus", exp_csr, csr_bus);
			end
			if (fetch_valid && decode_allowin)
				pending.push_back(fetch_bus);
		end
	end

	task automatic issue(word_t inst);
		fetch_bus = '{pc: 32'h0000_1000 + 4 * pending.size(), inst: inst};
		fetch_valid = 1'b1;
		@(posedge clock);
		#1 fetch_valid = 1'b0;
	endtask

	task automatic write_reg(reg_addr_t addr, word_t data);
		rf_wen = 1'b1;
		rf_waddr = addr;
		rf_wdata = data;
		@(posedge clock);
		if (addr != 0)
			shadow_regs[addr] = data;
		#1 rf_wen = 1'b0;
	endtask

	task automatic write_csr(csr_addr_t addr, word_t data);
		csr_wen = 1'b1;
		csr_waddr = addr;
		csr_wdata = data;
		@(posedge clock);
		case (addr)
			CSR_MSTATUS: shadow_csrs[0] = data;
			CSR_MTVEC: shadow_csrs[1] = data;
			CSR_MEPC: shadow_csrs[2] = data;
			CSR_MCAUSE: shadow_csrs[3] = data;
			default: ;
		endcase
		#1 csr_wen = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		fetch_bus = '0;
		fetch_valid = 1'b0;
		exu_allowin = 1'b1;
		rf_wen = 1'b0;
		rf_waddr = '0;
		rf_wdata = '0;
		csr_wen = 1'b0;
		csr_waddr = '0;
		csr_wdata = '0;
		shadow_regs = '{default: '0};
		shadow_csrs = '{default: '0};
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;
		assert (!decode_valid && decode_allowin) else report_error("wrong handshake after reset");

		// first item must show up one edge after acceptance
		fetch_bus = '{pc: 32'h0000_0ff0, inst: {12'h001, 5'd0, 3'b000, 5'd1, OPC_OP_IMM}};
		fetch_valid = 1'b1;
		@(posedge clock);
		#1 fetch_valid = 1'b0;
		assert (decode_valid) else report_error("first item not valid one edge after acceptance");

		write_reg(5'd1, 32'h1234_5678);
		write_reg(5'd2, 32'hffff_fff0);
		write_reg(5'd0, 32'hdead_beef);
		issue({7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP});
		issue({7'h20, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP});
		issue({7'h00, 5'd0, 5'd2, 3'b111, 5'd3, OPC_OP});
		issue({12'hfff, 5'd0, 3'b110, 5'd4, OPC_OP_IMM});
		issue({7'h20, 5'd3, 5'd1, 3'b101, 5'd5, OPC_OP_IMM});
		issue({20'habcde, 5'd6, OPC_LUI});
		issue({20'h80001, 5'd7, OPC_AUIPC});
		issue({20'h8020f, 5'd1, OPC_JAL});
		issue({12'h7f0, 5'd1, 3'b000, 5'd8, OPC_JALR});
		issue({12'hffc, 5'd2, 3'b010, 5'd9, OPC_LOAD});
		issue({12'h003, 5'd1, 3'b100, 5'd9, OPC_LOAD});
		issue({7'h7f, 5'd1, 5'd2, 3'b000, 5'b11001, OPC_STORE});
		issue({7'h01, 5'd2, 5'd1, 3'b001, 5'b10000, OPC_STORE});
		issue({7'h7f, 5'd2, 5'd1, 3'b001, 5'b11001, OPC_BRANCH});
		issue({7'h00, 5'd2, 5'd1, 3'b111, 5'b01000, OPC_BRANCH});
		write_csr(CSR_MTVEC, 32'h0000_0100);
		write_csr(CSR_MEPC, 32'h0000_2468);
		write_csr(CSR_MSTATUS, 32'h0000_1888);
		write_csr(CSR_MCAUSE, 32'h8000_0007);
		write_csr(12'h7c0, 32'h5555_5555);
		issue({CSR_MSTATUS, 5'd1, 3'b001, 5'd10, OPC_SYSTEM});
		issue({CSR_MCAUSE, 5'd2, 3'b010, 5'd11, OPC_SYSTEM});
		issue({12'h7c0, 5'd1, 3'b010, 5'd11, OPC_SYSTEM});
		issue(INST_ECALL);
		issue(INST_MRET);
		for (int i = 1; i < 32; i++)
			write_reg(i[4:0], $random(seed));

		// random traffic with back-pressure
		for (int i = 0; i < 300; i++)
			stim[i] = rand_inst();
		idx = 0;
		waited = 0;
		took = 1'b0;
		while (idx < 300) begin
			@(negedge clock);
			took = fetch_valid && decode_allowin;
			@(posedge clock);
			#1;
			if (took) begin
				idx++;
				waited = 0;
			end
			waited++;
			assert (waited < 100) else report_error("fetch item was not accepted in time");
			exu_allowin = ($random(seed) & 1) != 0;
			fetch_valid = (idx < 300) && ($random(seed) & 1);
			fetch_bus = '{pc: 32'h0001_0000 + 4 * idx, inst: stim[idx % 300]};
		end
		fetch_valid = 1'b0;
		exu_allowin = 1'b1;
		waited = 0;
		while (decode_valid || pending.size() > 0) begin
			@(posedge clock);
			#1 waited++;
			assert (waited < 20) else report_error("stage did not drain");
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
rv_decode_pkg.sv
reg_file.sv
csr_file.sv
decode_stage.sv
decode_top.sv
tb_decode_top.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator, then search the log for the failure line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_decode_top -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
test -f sim.log || exit 1
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
